// File: tb.f
+incdir+common
common/buf_pkg.sv
common/tm_pkg.sv
verilog/sync_fifo.sv
poll/asa_poll_stage.sv
read_count/read_count_tracker.sv
verilog/release_merger.sv
verilog/asa_tm_interface.sv
tb/tb_asa_tm.sv

// File: Makefile
TOP := tb_asa_tm

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: tb/tb_asa_tm.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the ASA/TM interface with an in-order TM responder and a read-count model
// every wait has its own timeout, a timeout ends the run at once
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "asa_defines.svh"

module tb_asa_tm;
	import tm_pkg::*;
	import buf_pkg::*;

	logic clk;
	logic rst_n;
	logic rep_req_valid;
	rep_req_t rep_req;
	logic tm_ack_valid;
	tm_ack_t tm_ack;
	logic discard_valid;
	buf_release_t discard;
	logic rep_bp;
	logic tm_poll_valid;
	tm_poll_t tm_poll;
	logic tm_enq_valid;
	tm_enq_t tm_enq;
	logic bm_release_valid;
	buf_release_t bm_release;

	integer seed = 55688;
	integer errors = 0;
	integer enq_seen = 0;
	integer rel_seen = 0;
	integer enq_expected = 0;
	integer req_sent = 0;
	integer polls_seen = 0;
	integer acks_sent = 0;
	integer disc_req = 0;
	integer disc_done = 0;
	bit ack_hold = 1'b0;
	bit ack_drop_en = 1'b0;
	bit disc_on_trk = 1'b0;
	buf_release_t disc_data = '0;
	rep_req_t req_log [256];
	read_count_t ref_cnt [64];
	tm_enq_t exp_enq_q [$];
	buf_release_t exp_rel_q [$];
	bit pipe_v [2];
	buf_release_t pipe_d [2];

	asa_tm_interface asa_tm_interface_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (tm_enq_valid) begin
			enq_seen++;
			assert (exp_enq_q.size() > 0) else begin
				$display("unexpected enqueue while no surviving copy was waiting");
				errors++;
			end
			if (exp_enq_q.size() > 0) begin
				assert (tm_enq == exp_enq_q[0]) else begin
					$display("[FAIL] tm_enq exp %h got %h", exp_enq_q[0], tm_enq);
					errors++;
				end
				void'(exp_enq_q.pop_front());
			end
		end
		if (bm_release_valid) begin
			rel_seen++;
			assert (exp_rel_q.size() > 0) else begin
				$display("unexpected buffer release while none was expected");
				errors++;
			end
			if (exp_rel_q.size() > 0) begin
				assert (bm_release == exp_rel_q[0]) else begin
					$display("[FAIL] bm_release exp %h got %h", exp_rel_q[0], bm_release);
					errors++;
				end
				void'(exp_rel_q.pop_front());
			end
		end
	end

	// TM model: draws at the falling edge, answers polls in order at the rising edge
	initial begin : tm_responder
		logic [31:0] r;
		rep_req_t req;
		tm_ack_t ack;
		tm_enq_t enq;
		buf_release_t rel;
		tm_ack_valid = 1'b0;
		tm_ack = '0;
		discard_valid = 1'b0;
		discard = '0;
		pipe_v[0] = 1'b0;
		pipe_v[1] = 1'b0;
		for (int i = 0; i < 64; i++) begin
			ref_cnt[i] = '0;
		end
		forever begin
			@(negedge clk);
			r = $random(seed);
			@(posedge clk);
			if (tm_poll_valid) begin
				assert (tm_poll == {req_log[polls_seen].qid, req_log[polls_seen].desc.src_port})
				else begin
					$display("[FAIL] tm_poll exp %h got %h",
						{req_log[polls_seen].qid, req_log[polls_seen].desc.src_port}, tm_poll);
					errors++;
				end
				polls_seen++;
			end
			// a discard sampled together with a tracker release goes out first
			if (disc_req != disc_done && (!disc_on_trk || pipe_v[1])) begin
				discard_valid <= 1'b1;
				discard <= disc_data;
				rel = disc_data;
				rel.read_count = '0;
				exp_rel_q.push_back(rel);
				disc_done++;
			end else begin
				discard_valid <= 1'b0;
			end
			if (pipe_v[1]) begin
				exp_rel_q.push_back(pipe_d[1]);
			end
			pipe_v[1] = pipe_v[0]; // ack to tracker release takes two cycles
			pipe_d[1] = pipe_d[0];
			pipe_v[0] = 1'b0;
			if (acks_sent < polls_seen && !ack_hold && r[0]) begin
				req = req_log[acks_sent];
				ack = {r[1] & r[2] & ack_drop_en, r[12:3], r[20:13], r[26:21], r[30:27]};
				tm_ack_valid <= 1'b1;
				tm_ack <= ack;
				if (!(req.drop || ack.drop)) begin
					enq.qid = req.qid;
					enq.conn_id = ack.conn_id;
					enq.conn_group_id = ack.conn_group_id;
					enq.port_queue_id = ack.port_queue_id;
					enq.desc = req.desc;
					enq.desc.dst_port = ack.port_id;
					exp_enq_q.push_back(enq);
					enq_expected++;
					ref_cnt[req.packet_id]++;
				end
				if (req.ucast || req.last) begin
					pipe_v[0] = 1'b1;
					pipe_d[0] = {ref_cnt[req.packet_id], req.desc.src_port, req.desc.buf_ptr,
						req.desc.packet_length};
					ref_cnt[req.packet_id] = '0;
				end
				acks_sent++;
			end else begin
				tm_ack_valid <= 1'b0;
			end
		end
	end

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %0s", what);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic send_req(input logic [5:0] pid, input logic ucast, input logic last,
			input logic drop);
		rep_req_t req;
		logic [31:0] r;
		@(posedge clk);
		r = $random(seed);
		req.packet_id = pid;
		req.qid = r[7:0];
		req.ucast = ucast;
		req.last = last;
		req.drop = drop;
		req.desc.src_port = r[11:8];
		req.desc.dst_port = r[15:12];
		req.desc.buf_ptr = r[27:16];
		r = $random(seed);
		req.desc.packet_length = r[13:0];
		req_log[req_sent] = req;
		req_sent++;
		rep_req_valid <= 1'b1;
		rep_req <= req;
		@(posedge clk);
		rep_req_valid <= 1'b0;
	endtask

	// waits until every copy is answered and every expected output has been seen
	task automatic wait_drain(input string what);
		integer t;
		t = 0;
		@(negedge clk);
		while (!(acks_sent == req_sent && exp_enq_q.size() == 0 && exp_rel_q.size() == 0
				&& !pipe_v[0] && !pipe_v[1] && disc_done == disc_req) && t < 500) begin
			@(negedge clk);
			t++;
		end
		if (t >= 500) begin
			timeout_fail(what);
		end
		repeat (4) @(negedge clk); // room for any stray output
	endtask

	task automatic check_count(input string name, input integer got, input integer exp);
		assert (got == exp) else begin
			$display("[FAIL] %0s exp %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input integer err0);
		$display("test %0s finished with %0d errors", name, errors - err0);
	endtask

	initial begin : stimulus
		integer e0;
		integer q0;
		integer x0;
		integer r0;
		integer n;
		integer t;
		bit bp_seen;
		rst_n = 1'b0;
		rep_req_valid = 1'b0;
		rep_req = '0;

		e0 = errors;
		repeat (2) begin
			@(negedge clk);
			assert (!(rep_bp | tm_poll_valid | tm_enq_valid | bm_release_valid)) else begin
				$display("an output strobe or rep_bp was high during reset");
				errors++;
			end
		end
		@(posedge clk);
		rst_n <= 1'b1;
		q0 = enq_seen;
		r0 = rel_seen;
		send_req(6'd1, 1'b1, 1'b0, 1'b0);
		// together with send_req this covers 66 cycles after reset release
		repeat (64) begin
			@(negedge clk);
			assert (!tm_poll_valid) else begin
				$display("a poll was issued before the init sweep finished");
				errors++;
			end
		end
		report_test("reset and init", e0);

		e0 = errors;
		wait_drain("the unicast copy");
		check_count("tm_enq count", enq_seen - q0, 1);
		check_count("bm_release count", rel_seen - r0, 1);
		report_test("unicast", e0);

		e0 = errors;
		ack_drop_en <= 1'b1;
		q0 = enq_seen;
		x0 = enq_expected;
		r0 = rel_seen;
		for (int i = 0; i < 6; i++) begin
			send_req(6'd5, 1'b0, i == 5, i == 1 || i == 3);
		end
		wait_drain("the multicast copies");
		check_count("tm_enq count", enq_seen - q0, enq_expected - x0);
		check_count("bm_release count", rel_seen - r0, 1);
		report_test("multicast with drops", e0);

		e0 = errors;
		ack_drop_en <= 1'b0;
		q0 = enq_seen;
		r0 = rel_seen;
		for (int i = 0; i < 3; i++) begin
			send_req(6'd9, 1'b0, i == 2, 1'b1);
		end
		wait_drain("the dropped copies");
		check_count("tm_enq count", enq_seen - q0, 0);
		check_count("bm_release count", rel_seen - r0, 1);
		report_test("all copies dropped", e0);

		e0 = errors;
		r0 = rel_seen;
		disc_data <= {5'd7, 4'h3, 12'habc, 14'h0155};
		disc_on_trk <= 1'b0;
		disc_req <= disc_req + 1;
		wait_drain("a lone discard");
		check_count("bm_release count", rel_seen - r0, 1);
		disc_data <= {5'd2, 4'h9, 12'h5a5, 14'h2a0f};
		disc_on_trk <= 1'b1; // lands on the same cycle as the tracker release
		disc_req <= disc_req + 1;
		send_req(6'd12, 1'b1, 1'b0, 1'b0);
		wait_drain("a discard merged with a tracker release");
		check_count("bm_release count", rel_seen - r0, 3);
		report_test("discard merge", e0);

		e0 = errors;
		ack_hold <= 1'b1;
		n = 0;
		bp_seen = 1'b0;
		while (!bp_seen && n < 40) begin
			@(negedge clk);
			if (rep_bp) begin
				bp_seen = 1'b1;
			end else begin
				send_req(n[5:0], 1'b1, 1'b0, 1'b0);
				n++;
			end
		end
		assert (bp_seen) else begin
			$display("rep_bp never rose while acknowledges were held");
			errors++;
		end
		// pending FIFO full plus more than BP_ON waiting, and no overflow of the request FIFO
		assert (n > (1 << `ASA_REQ_FIFO_DEPTH_NBITS) + `ASA_BP_ON
				&& n <= (2 << `ASA_REQ_FIFO_DEPTH_NBITS)) else begin
			$display("[FAIL] requests before rep_bp exp %h got %h",
				(1 << `ASA_REQ_FIFO_DEPTH_NBITS) + `ASA_BP_ON + 1, n);
			errors++;
		end
		repeat (8) @(posedge clk);
		ack_hold <= 1'b0;
		t = 0;
		@(negedge clk);
		while (rep_bp && t < 200) begin
			@(negedge clk);
			t++;
		end
		if (t >= 200) begin
			timeout_fail("rep_bp to fall");
		end
		// requests sent and not yet polled are the ones still in the request FIFO
		assert (req_sent - polls_seen == `ASA_BP_OFF - 1) else begin
			$display("[FAIL] requests waiting when rep_bp fell exp %h got %h",
				`ASA_BP_OFF - 1, req_sent - polls_seen);
			errors++;
		end
		wait_drain("the held copies");
		report_test("back-pressure", e0);

		$display("tests 6, errors %0d, enqueues %0d, releases %0d", errors, enq_seen, rel_seen);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/asa_tm_interface.sv
// ~~~~~~~~~~~~~~~~~~~~
// replication engine to TM interface, strobes only, no back-pressure from TM or BM
// the replication engine must stop within a few cycles of rep_bp
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module asa_tm_interface (
	input  logic clk,
	input  logic rst_n,
	input  logic rep_req_valid,
	input  tm_pkg::rep_req_t rep_req,
	input  logic tm_ack_valid,
	input  tm_pkg::tm_ack_t tm_ack,
	input  logic discard_valid,
	input  buf_pkg::buf_release_t discard,
	output logic rep_bp,
	output logic tm_poll_valid,
	output tm_pkg::tm_poll_t tm_poll,
	output logic tm_enq_valid,
	output tm_pkg::tm_enq_t tm_enq,
	output logic bm_release_valid,
	output buf_pkg::buf_release_t bm_release
);
	import tm_pkg::*;
	import buf_pkg::*;

	logic init_done;
	logic copy_valid;
	resolved_copy_t copy;
	logic trk_valid;
	buf_release_t trk_release;

	asa_poll_stage poll_stage_i (
		.clk(clk),
		.rst_n(rst_n),
		.rep_req_valid(rep_req_valid),
		.rep_req(rep_req),
		.init_done(init_done),
		.tm_ack_valid(tm_ack_valid),
		.tm_ack(tm_ack),
		.rep_bp(rep_bp),
		.tm_poll_valid(tm_poll_valid),
		.tm_poll(tm_poll),
		.tm_enq_valid(tm_enq_valid),
		.tm_enq(tm_enq),
		.copy_valid(copy_valid),
		.copy(copy)
	);

	read_count_tracker tracker_i (
		.clk(clk),
		.rst_n(rst_n),
		.copy_valid(copy_valid),
		.copy(copy),
		.init_done(init_done),
		.trk_valid(trk_valid),
		.trk_release(trk_release)
	);

	release_merger merger_i (
		.clk(clk),
		.rst_n(rst_n),
		.discard_valid(discard_valid),
		.discard(discard),
		.trk_valid(trk_valid),
		.trk_release(trk_release),
		.bm_release_valid(bm_release_valid),
		.bm_release(bm_release)
	);

endmodule

`default_nettype wire

// File: verilog/release_merger.sv
// ~~~~~~~~~~~~~~~~~~~~
// discards win the output, tracker releases queue behind them
// the release FIFO must cover the longest discard burst
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "asa_defines.svh"

module release_merger (
	input  logic clk,
	input  logic rst_n,
	input  logic discard_valid,
	input  buf_pkg::buf_release_t discard,
	input  logic trk_valid,
	input  buf_pkg::buf_release_t trk_release,
	output logic bm_release_valid,
	output buf_pkg::buf_release_t bm_release
);
	import buf_pkg::*;

	buf_release_t rel_head;
	logic rel_empty;
	logic rel_wr;
	logic rel_pop;

	// a tracker release bypasses the queue when nothing is ahead of it
	assign rel_wr = trk_valid & (discard_valid | ~rel_empty);
	assign rel_pop = ~rel_empty & ~discard_valid;

	sync_fifo #(.width($bits(buf_release_t)), .depth_nbits(`ASA_REL_FIFO_DEPTH_NBITS)) rel_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr(rel_wr),
		.din(trk_release),
		.rd(rel_pop),
		.dout(rel_head),
		.empty(rel_empty),
		.full(),
		.count()
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bm_release_valid <= 1'b0;
		end else begin
			bm_release_valid <= discard_valid | ~rel_empty | trk_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (discard_valid) begin
			bm_release <= discard;
			bm_release.read_count <= '0;
		end else if (!rel_empty) begin
			bm_release <= rel_head;
		end else if (trk_valid) begin
			bm_release <= trk_release;
		end
	end

endmodule

`default_nettype wire

// File: read_count/read_count_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~
// counts surviving copies per packet id, releases the buffer on the final copy
// copies must not arrive before init_done, the sweep owns the table until then
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "asa_defines.svh"

module read_count_tracker (
	input  logic clk,
	input  logic rst_n,
	input  logic copy_valid,
	input  tm_pkg::resolved_copy_t copy,
	output logic init_done,
	output logic trk_valid,
	output buf_pkg::buf_release_t trk_release
);
	import buf_pkg::*;

	localparam int num_pkt_ids = 1 << `ASA_PACKET_ID_NBITS;

	init_state_e init_state;
	logic [`ASA_PACKET_ID_NBITS-1:0] init_idx;
	read_count_t cnt_mem [num_pkt_ids];
	read_count_t final_count;
	logic final_copy;

	// the port name hides the enum literal, hence the scoped names below
	assign init_done = (init_state == buf_pkg::init_done);

	assign final_copy = copy.ucast | copy.last;
	assign final_count = cnt_mem[copy.packet_id] + (copy.drop ? 1'b0 : 1'b1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			init_state <= buf_pkg::init_idle;
			init_idx <= '0;
		end else begin
			case (init_state)
				buf_pkg::init_idle: init_state <= buf_pkg::init_clear;
				buf_pkg::init_clear: begin
					init_idx <= init_idx + 1'b1;
					if (&init_idx) begin
						init_state <= buf_pkg::init_done;
					end
				end
				buf_pkg::init_done: init_state <= buf_pkg::init_done;
				default: init_state <= buf_pkg::init_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (init_state == buf_pkg::init_clear) begin
			cnt_mem[init_idx] <= '0;
		end else if (copy_valid) begin
			cnt_mem[copy.packet_id] <= final_copy ? '0 : final_count;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			trk_valid <= 1'b0;
		end else begin
			trk_valid <= copy_valid & final_copy;
		end
	end

	always_ff @(posedge clk) begin
		if (copy_valid & final_copy) begin
			trk_release.read_count <= final_count; // 0 when every copy was dropped
			trk_release.port_id <= copy.desc.src_port;
			trk_release.buf_ptr <= copy.desc.buf_ptr;
			trk_release.packet_length <= copy.desc.packet_length;
		end
	end

endmodule

`default_nettype wire

// File: poll/asa_poll_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// the TM must acknowledge every poll once, in poll order, a cycle or more later
// no polls are issued until init_done from the tracker
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "asa_defines.svh"

module asa_poll_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic rep_req_valid,
	input  tm_pkg::rep_req_t rep_req,
	input  logic init_done,
	input  logic tm_ack_valid,
	input  tm_pkg::tm_ack_t tm_ack,
	output logic rep_bp,
	output logic tm_poll_valid,
	output tm_pkg::tm_poll_t tm_poll,
	output logic tm_enq_valid,
	output tm_pkg::tm_enq_t tm_enq,
	output logic copy_valid,
	output tm_pkg::resolved_copy_t copy
);
	import tm_pkg::*;

	rep_req_t req_head;
	rep_req_t pend_head;
	resolved_copy_t resolved;
	logic req_empty;
	logic pend_full;
	logic req_pop;
	logic [`ASA_REQ_FIFO_DEPTH_NBITS:0] req_count;

	assign req_pop = ~req_empty & ~pend_full & init_done;

	sync_fifo #(.width($bits(rep_req_t)), .depth_nbits(`ASA_REQ_FIFO_DEPTH_NBITS)) req_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr(rep_req_valid),
		.din(rep_req),
		.rd(req_pop),
		.dout(req_head),
		.empty(req_empty),
		.full(),
		.count(req_count)
	);

	// polled copies wait here for their in-order acknowledge
	sync_fifo #(.width($bits(rep_req_t)), .depth_nbits(`ASA_REQ_FIFO_DEPTH_NBITS)) pend_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr(req_pop),
		.din(req_head),
		.rd(tm_ack_valid),
		.dout(pend_head),
		.empty(),
		.full(pend_full),
		.count()
	);

	always_comb begin
		resolved.packet_id = pend_head.packet_id;
		resolved.ucast = pend_head.ucast;
		resolved.last = pend_head.last;
		resolved.drop = pend_head.drop | tm_ack.drop;
		resolved.desc = pend_head.desc;
		resolved.desc.dst_port = tm_ack.port_id; // egress port chosen by the TM
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tm_poll_valid <= 1'b0;
			tm_enq_valid <= 1'b0;
			copy_valid <= 1'b0;
			rep_bp <= 1'b0;
		end else begin
			tm_poll_valid <= req_pop;
			tm_enq_valid <= tm_ack_valid & ~resolved.drop;
			copy_valid <= tm_ack_valid; // dropped copies still reach the tracker
			if (req_count > `ASA_BP_ON) begin
				rep_bp <= 1'b1;
			end else if (req_count < `ASA_BP_OFF) begin
				rep_bp <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_pop) begin
			tm_poll.qid <= req_head.qid;
			tm_poll.src_port <= req_head.desc.src_port;
		end
		if (tm_ack_valid) begin
			copy <= resolved;
			tm_enq.qid <= pend_head.qid;
			tm_enq.conn_id <= tm_ack.conn_id;
			tm_enq.conn_group_id <= tm_ack.conn_group_id;
			tm_enq.port_queue_id <= tm_ack.port_queue_id;
			tm_enq.desc <= resolved.desc;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sync_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// single-clock register FIFO, head is visible on dout while not empty
// writes to a full FIFO are dropped unless a read happens in the same cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int width = 8,
	parameter int depth_nbits = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic wr,
	input  logic [width-1:0] din,
	input  logic rd,
	output logic [width-1:0] dout,
	output logic empty,
	output logic full,
	output logic [depth_nbits:0] count
);
	localparam int depth = 1 << depth_nbits;

	logic [width-1:0] mem [depth];
	logic [depth_nbits-1:0] wr_ptr;
	logic [depth_nbits-1:0] rd_ptr;
	logic wr_en;
	logic rd_en;

	assign rd_en = rd & ~empty;
	assign wr_en = wr & (~full | rd_en);
	assign empty = (count == '0);
	assign full = count[depth_nbits]; // count never exceeds depth
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: common/tm_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// replication-engine and traffic-manager side structs
// the descriptor type comes from buf_pkg, so compile that first
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "asa_defines.svh"

package tm_pkg;

	typedef struct packed {
		logic [`ASA_PACKET_ID_NBITS-1:0] packet_id;
		logic [`ASA_QID_NBITS-1:0] qid;
		logic ucast;
		logic last; // last copy of a multicast packet
		logic drop;
		buf_pkg::pkt_desc_t desc;
	} rep_req_t;

	typedef struct packed {
		logic [`ASA_QID_NBITS-1:0] qid;
		logic [`ASA_PORT_ID_NBITS-1:0] src_port;
	} tm_poll_t;

	typedef struct packed {
		logic drop;
		logic [`ASA_CONN_ID_NBITS-1:0] conn_id;
		logic [`ASA_CONN_GROUP_NBITS-1:0] conn_group_id;
		logic [`ASA_PORT_QUEUE_NBITS-1:0] port_queue_id;
		logic [`ASA_PORT_ID_NBITS-1:0] port_id;
	} tm_ack_t;

	typedef struct packed {
		logic [`ASA_QID_NBITS-1:0] qid;
		logic [`ASA_CONN_ID_NBITS-1:0] conn_id;
		logic [`ASA_CONN_GROUP_NBITS-1:0] conn_group_id;
		logic [`ASA_PORT_QUEUE_NBITS-1:0] port_queue_id;
		buf_pkg::pkt_desc_t desc;
	} tm_enq_t;

	// drop here is the request drop OR the acknowledge drop
	typedef struct packed {
		logic [`ASA_PACKET_ID_NBITS-1:0] packet_id;
		logic ucast;
		logic last;
		logic drop;
		buf_pkg::pkt_desc_t desc;
	} resolved_copy_t;

endpackage

`default_nettype wire

// File: common/buf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// buffer-side types: packet descriptor, read count and buffer release
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "asa_defines.svh"

package buf_pkg;

	typedef struct packed {
		logic [`ASA_PORT_ID_NBITS-1:0] src_port;
		logic [`ASA_PORT_ID_NBITS-1:0] dst_port;
		logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr;
		logic [`ASA_PACKET_LENGTH_NBITS-1:0] packet_length;
	} pkt_desc_t;

	typedef logic [`ASA_READ_COUNT_NBITS-1:0] read_count_t;

	// one buffer release towards the buffer manager
	typedef struct packed {
		read_count_t read_count;
		logic [`ASA_PORT_ID_NBITS-1:0] port_id;
		logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr;
		logic [`ASA_PACKET_LENGTH_NBITS-1:0] packet_length;
	} buf_release_t;

	typedef enum logic [1:0] {
		init_idle,
		init_clear, // counter table sweep in progress
		init_done
	} init_state_e;

endpackage

`default_nettype wire

// File: common/asa_defines.svh
// ~~~~~~~~~~~~~~~~~~~~
// widths, FIFO depths and back-pressure thresholds of the ASA/TM interface
// ASA_BP_ON must stay below the request FIFO depth, ASA_BP_OFF below ASA_BP_ON
// ~~~~~~~~~~~~~~~~~~~~
`ifndef ASA_DEFINES_SVH
`define ASA_DEFINES_SVH

`define ASA_PACKET_ID_NBITS      6
`define ASA_QID_NBITS            8
`define ASA_CONN_ID_NBITS        10
`define ASA_CONN_GROUP_NBITS     8
`define ASA_PORT_QUEUE_NBITS     6
`define ASA_PORT_ID_NBITS        4
`define ASA_BUF_PTR_NBITS        12
`define ASA_PACKET_LENGTH_NBITS  14
`define ASA_READ_COUNT_NBITS     5

// request and pending FIFOs share this depth
`define ASA_REQ_FIFO_DEPTH_NBITS 4
`define ASA_REL_FIFO_DEPTH_NBITS 3

`define ASA_BP_ON                10
`define ASA_BP_OFF               6

`endif
